// ==== Bender.yml ====
package:
  name: cb_access

sources:
  - source/cb_pkg.sv
  - source/cb_cmd_decode.sv
  - source/cb_en_shift.sv
  - source/cb_addr_shift.sv
  - source/cb_bank_read.sv
  - source/cb_access_top.sv
  - target: simulation
    files:
      - sim/tb_cb_access.sv

// ==== sim/tb_cb_access.sv ====
/*
  Directed testbench for the covariance-bank access path
  Cycle model of decode, shifters and bank reads, checked every cycle
  Reset, preload, forward, reverse, new-landmark, handshake, random tests
*/
`timescale 1ns/1ps
module tb_cb_access import cb_pkg::*;;

  localparam int L          = 4;
  localparam int CB_AW      = 8;
  localparam int CB_DW      = 16;
  localparam int ROW_LEN    = 10;
  localparam int MAX_CYCLES = 6000;

  logic               clk;
  logic               sys_rst;
  logic               cmd_req;
  cb_dir_e            cmd_dir;
  logic [1:0]         cmd_lnum;
  logic [CB_AW-1:0]   cmd_base;
  logic [7:0]         cmd_len;
  logic               cmd_ack;
  logic               wr_en;
  logic [1:0]         wr_bank;
  logic [CB_AW-1:0]   wr_addr;
  logic [CB_DW-1:0]   wr_data;
  logic [L-1:0]       rd_en;
  logic [CB_DW*L-1:0] rd_data;

  // Model state of the decoder
  dec_state_e       m_state;
  cb_dir_e          m_dir_q;
  logic [1:0]       m_lnum_q;
  logic [7:0]       m_len;
  logic [7:0]       m_step;
  int               m_drain;
  logic [CB_AW-1:0] m_addr_ctr;
  logic             m_ack;
  // Model state of the shifters and result stage
  logic [L-1:0]     m_en;
  logic [CB_AW-1:0] m_addr [L];
  logic [L-1:1]     m_g;
  logic [L-1:0]     m_rd_en;
  logic [CB_DW-1:0] m_rd_data [L];

  int          cycle_cnt;
  int          err_cnt;
  logic [L-1:0] en_seen;
  logic [31:0] rng;

  cb_access_top #(.L(L), .CB_AW(CB_AW), .CB_DW(CB_DW), .ROW_LEN(ROW_LEN)) u_cb_access_top (
    .clk(clk), .sys_rst(sys_rst), .cmd_req(cmd_req), .cmd_dir(cmd_dir),
    .cmd_lnum(cmd_lnum), .cmd_base(cmd_base), .cmd_len(cmd_len), .cmd_ack(cmd_ack),
    .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_data(rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("ERROR: run exceeded its limit of %0d clock cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR: t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Preload pattern at bank b and address a
  function automatic logic [CB_DW-1:0] bank_word(input int b, input logic [CB_AW-1:0] a);
    return CB_DW'(b * 256 + a) ^ 16'h5a3c;
  endfunction

  // New-landmark lane pair with entry offset and partner decrement
  task automatic landmark_pair(input logic [1:0] ln, output int first, output int partner,
                               output logic [CB_AW-1:0] off, output logic [CB_AW-1:0] dec);
    case (ln)
      2'b11: begin
        first = 0;
        partner = 1;
        off = 0;
        dec = 0;
      end
      2'b00: begin
        first = 2;
        partner = 3;
        off = 0;
        dec = 0;
      end
      2'b01: begin
        first = 3;
        partner = 2;
        off = 3;
        dec = 1;
      end
      default: begin
        first = 1;
        partner = 0;
        off = 1;
        dec = 1;
      end
    endcase
  endtask

  // One clock edge of the whole path
  task automatic model_step();
    logic [L-1:0]     n_en;
    logic [CB_AW-1:0] n_addr [L];
    logic [L-1:1]     n_g;
    cb_dir_e          d;
    logic             e_new;
    logic             g_new;
    logic [CB_AW-1:0] a_new;
    int               first;
    int               partner;
    logic [CB_AW-1:0] off;
    logic [CB_AW-1:0] dec;
    if (sys_rst) begin
      m_state = ST_IDLE;
      m_dir_q = DIR_IDLE;
      m_lnum_q = 2'b00;
      m_len = 8'd0;
      m_step = 8'd0;
      m_drain = 0;
      m_addr_ctr = '0;
      m_ack = 1'b0;
      m_en = '0;
      m_g = '0;
      m_rd_en = '0;
      for (int i = 0; i < L; i++) begin
        m_addr[i] = '0;
        m_rd_data[i] = '0;
      end
    end else begin
      // Decode outputs before the edge
      d = (m_state == ST_RUN || m_state == ST_DRAIN) ? m_dir_q : DIR_IDLE;
      e_new = (m_state == ST_RUN);
      g_new = e_new & m_step[2];
      a_new = m_addr_ctr;
      // Result stage reads the old lanes
      for (int i = 0; i < L; i++) begin
        m_rd_en[i] = m_en[i];
        m_rd_data[i] = m_en[i] ? bank_word(i, m_addr[i]) : '0;
      end
      n_en = '0;
      for (int i = 0; i < L; i++)
        n_addr[i] = '0;
      case (d)
        DIR_POS: begin
          n_en[0] = e_new;
          n_addr[0] = e_new ? a_new : '0;
          for (int i = 1; i < L; i++) begin
            n_en[i] = m_en[i-1];
            if (m_g[i])
              n_addr[i] = m_en[i-1] ? m_addr[i-1] + 1'b1 : '0;
            else
              n_addr[i] = m_addr[i-1];
          end
        end
        DIR_NEG: begin
          n_en[L-1] = e_new;
          n_addr[L-1] = e_new ? a_new + CB_AW'(3) : '0;
          // Stage distance from the entry lane picks the delayed group bit
          for (int i = 0; i < L - 1; i++) begin
            n_en[i] = m_en[i+1];
            if (m_g[L-1-i])
              n_addr[i] = m_en[i+1] ? m_addr[i+1] - 1'b1 : '0;
            else
              n_addr[i] = m_addr[i+1];
          end
        end
        DIR_NEW: begin
          landmark_pair(m_lnum_q, first, partner, off, dec);
          n_en[first] = e_new;
          n_en[partner] = m_en[first];
          n_addr[first] = e_new ? a_new + off : '0;
          n_addr[partner] = m_en[first] ? m_addr[first] - dec : '0;
        end
        default: begin
          // Addresses hold and enables clear
          for (int i = 0; i < L; i++)
            n_addr[i] = m_addr[i];
        end
      endcase
      n_g[1] = g_new;
      for (int i = 2; i < L; i++)
        n_g[i] = m_g[i-1];
      // Decode FSM
      case (m_state)
        ST_IDLE: begin
          if (cmd_req) begin
            m_dir_q = cmd_dir;
            m_lnum_q = cmd_lnum;
            m_addr_ctr = cmd_base;
            m_len = cmd_len;
            m_step = 8'd0;
            m_drain = 0;
            m_state = (cmd_len == 8'd0) ? ST_DRAIN : ST_RUN;
          end
        end
        ST_RUN: begin
          m_step = m_step + 8'd1;
          m_addr_ctr = m_addr_ctr + CB_AW'(ROW_LEN);
          if (m_step == m_len)
            m_state = ST_DRAIN;
        end
        ST_DRAIN: begin
          m_drain++;
          if (m_drain == L + 1) begin
            m_state = ST_ACK;
            m_ack = 1'b1;
          end
        end
        default: begin
          if (!cmd_req) begin
            m_state = ST_IDLE;
            m_ack = 1'b0;
          end
        end
      endcase
      m_en = n_en;
      m_addr = n_addr;
      m_g = n_g;
    end
  endtask

  always @(posedge clk)
    model_step();

  // Compare away from the active edge
  always @(negedge clk) begin
    if (!sys_rst) begin
      for (int i = 0; i < L; i++) begin
        check_val($sformatf("rd_en[%0d]", i), m_rd_en[i], rd_en[i]);
        check_val($sformatf("rd_data[%0d]", i), m_rd_data[i], rd_data[i*CB_DW +: CB_DW]);
      end
      check_val("cmd_ack", m_ack, cmd_ack);
    end
  end

  // Full four-phase handshake with req held for hold cycles past ack
  task automatic run_cmd(input cb_dir_e d, input logic [1:0] ln, input logic [CB_AW-1:0] base,
                         input logic [7:0] len, input int hold);
    int cycles;
    cycles = 0;
    en_seen = '0;
    cmd_dir = d;
    cmd_lnum = ln;
    cmd_base = base;
    cmd_len = len;
    cmd_req = 1'b1;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      en_seen = en_seen | rd_en;
    end while (cmd_ack !== 1'b1);
    check_val("ack_latency", len + L + 2, cycles);
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_val("cmd_ack", 1'b1, cmd_ack);
    end
    cmd_req = 1'b0;
    @(posedge clk);
    #1;
    check_val("cmd_ack", 1'b0, cmd_ack);
  endtask

  task automatic reset_and_preload();
    check_val("cmd_ack", 1'b0, cmd_ack);
    check_val("rd_en", '0, rd_en);
    for (int b = 0; b < L; b++) begin
      for (int a = 0; a < 2 ** CB_AW; a++) begin
        wr_en = 1'b1;
        wr_bank = 2'(b);
        wr_addr = CB_AW'(a);
        wr_data = bank_word(b, CB_AW'(a));
        @(posedge clk);
        #1;
      end
    end
    wr_en = 1'b0;
  endtask

  task automatic forward_mapping();
    run_cmd(DIR_POS, 2'b00, 8'h20, 8'd12, 0);
    check_val("rd_en_seen", 4'hf, en_seen);
  endtask

  task automatic reverse_mapping();
    run_cmd(DIR_NEG, 2'b00, 8'h40, 8'd12, 0);
    check_val("rd_en_seen", 4'hf, en_seen);
  endtask

  task automatic new_landmark_mapping();
    logic [1:0]       order [4];
    int               first;
    int               partner;
    logic [CB_AW-1:0] off;
    logic [CB_AW-1:0] dec;
    order = '{2'b11, 2'b00, 2'b01, 2'b10};
    for (int k = 0; k < 4; k++) begin
      run_cmd(DIR_NEW, order[k], 8'h60 + 8'(k * 16), 8'd6, 0);
      landmark_pair(order[k], first, partner, off, dec);
      // Only the pair lanes ever light up
      check_val("rd_en_seen", (1 << first) | (1 << partner), en_seen);
    end
  endtask

  task automatic handshake_idle();
    run_cmd(DIR_IDLE, 2'b00, 8'h10, 8'd5, 3);
    check_val("rd_en_seen", '0, en_seen);
    // Back-to-back command right after the ack drops
    run_cmd(DIR_POS, 2'b00, 8'h80, 8'd3, 0);
    check_val("rd_en_seen", 4'hf, en_seen);
    // Empty command only flushes
    run_cmd(DIR_POS, 2'b00, 8'h90, 8'd0, 0);
    check_val("rd_en_seen", '0, en_seen);
  endtask

  task automatic random_sequence();
    for (int n = 0; n < 20; n++) begin
      rng = next_rand(rng);
      run_cmd(cb_dir_e'(rng[1:0]), rng[3:2], rng[15:8], 8'(rng[23:20]) + 8'd1, 0);
    end
  endtask

  initial begin
    sys_rst = 1'b1;
    cmd_req = 1'b0;
    cmd_dir = DIR_IDLE;
    cmd_lnum = 2'b00;
    cmd_base = '0;
    cmd_len = 8'd0;
    wr_en = 1'b0;
    wr_bank = 2'b00;
    wr_addr = '0;
    wr_data = '0;
    cycle_cnt = 0;
    err_cnt = 0;
    en_seen = '0;
    rng = 32'h66e9;
    repeat (16) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    reset_and_preload();
    forward_mapping();
    reverse_mapping();
    new_landmark_mapping();
    handshake_idle();
    random_sequence();
    // Let the last reads settle
    repeat (4) @(posedge clk);
    #1;
    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// ==== source/cb_access_top.sv ====
/*
  Covariance bank access path, top level
  Decode, enable and address shifters, bank read
*/
`timescale 1ns/1ps
module cb_access_top import cb_pkg::*; #(
  parameter int L       = 4,
  parameter int CB_AW   = 8,
  parameter int CB_DW   = 16,
  parameter int ROW_LEN = 10
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               cmd_req,
  input  cb_dir_e            cmd_dir,
  input  logic [1:0]         cmd_lnum,
  input  logic [CB_AW-1:0]   cmd_base,
  input  logic [7:0]         cmd_len,
  output logic               cmd_ack,
  input  logic               wr_en,
  input  logic [1:0]         wr_bank,
  input  logic [CB_AW-1:0]   wr_addr,
  input  logic [CB_DW-1:0]   wr_data,
  output logic [L-1:0]       rd_en,
  output logic [CB_DW*L-1:0] rd_data
);

  cb_dir_e            dir;
  logic [1:0]         lnum;
  logic [CB_AW-1:0]   addr_new;
  logic               en_new;
  logic               group_bit;
  logic [L-1:0]       cb_en;
  logic [CB_AW*L-1:0] cb_addr;

  // Decode stage
  cb_cmd_decode #(.CB_AW(CB_AW), .ROW_LEN(ROW_LEN), .L(L)) u_decode (
    .clk(clk), .sys_rst(sys_rst), .cmd_req(cmd_req), .cmd_dir(cmd_dir),
    .cmd_lnum(cmd_lnum), .cmd_base(cmd_base), .cmd_len(cmd_len),
    .cmd_ack(cmd_ack), .dir(dir), .lnum(lnum), .addr_new(addr_new),
    .en_new(en_new), .group_bit(group_bit)
  );

  // Execute stage, both shifters see the same old cb_en
  cb_en_shift #(.L(L)) u_en_shift (
    .clk(clk), .sys_rst(sys_rst), .dir(dir), .lnum(lnum),
    .en_new(en_new), .cb_en(cb_en)
  );

  cb_addr_shift #(.L(L), .CB_AW(CB_AW)) u_addr_shift (
    .clk(clk), .sys_rst(sys_rst), .dir(dir), .lnum(lnum),
    .group_bit(group_bit), .en_new(en_new), .cb_en(cb_en),
    .addr_new(addr_new), .cb_addr(cb_addr)
  );

  // Result stage
  cb_bank_read #(.L(L), .CB_AW(CB_AW), .CB_DW(CB_DW)) u_bank_read (
    .clk(clk), .sys_rst(sys_rst), .cb_en(cb_en), .cb_addr(cb_addr),
    .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_data(rd_data)
  );

endmodule

// ==== source/cb_addr_shift.sv ====
/*
  Bank address shifter
  Group-bit delay line, neighbour-to-neighbour address moves
  Plus/minus one at group boundaries, landmark-pair mapping
*/
`timescale 1ns/1ps
module cb_addr_shift import cb_pkg::*; #(
  parameter int L     = 4,
  parameter int CB_AW = 8
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  cb_dir_e            dir,
  input  logic [1:0]         lnum,
  input  logic               group_bit,
  input  logic               en_new,
  input  logic [L-1:0]       cb_en,
  input  logic [CB_AW-1:0]   addr_new,
  output logic [CB_AW*L-1:0] cb_addr
);

  // g_d[i] is group_bit delayed by i cycles
  logic [L-1:1]     g_d;
  int unsigned      first_lane;
  int unsigned      partner_lane;
  logic [CB_AW-1:0] new_off;
  logic             pair_dec;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      g_d <= '0;
    end else begin
      g_d[1] <= group_bit;
      for (int i = 2; i < L; i++)
        g_d[i] <= g_d[i-1];
    end
  end

  // New-landmark pair and its offsets
  assign first_lane   = nl_first_lane(lnum);
  assign partner_lane = nl_partner_lane(lnum);
  assign new_off      = (lnum == 2'b01) ? CB_AW'(3) :
                        (lnum == 2'b10) ? CB_AW'(1) : '0;
  // Downward pairs step back by one
  assign pair_dec     = (lnum == 2'b01) || (lnum == 2'b10);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cb_addr <= '0;
    end else begin
      case (dir)
        DIR_POS: begin
          cb_addr[0 +: CB_AW] <= en_new ? addr_new : '0;
          for (int i = 1; i < L; i++) begin
            // Boundary reached this stage
            if (g_d[i])
              cb_addr[i*CB_AW +: CB_AW] <= cb_en[i-1] ?
                cb_addr[(i-1)*CB_AW +: CB_AW] + CB_AW'(1) : '0;
            else
              cb_addr[i*CB_AW +: CB_AW] <= cb_addr[(i-1)*CB_AW +: CB_AW];
          end
        end
        DIR_NEG: begin
          cb_addr[(L-1)*CB_AW +: CB_AW] <= en_new ? addr_new + CB_AW'(3) : '0;
          // Lane i sits L-1-i stages from the entry lane
          for (int i = 0; i < L - 1; i++) begin
            if (g_d[L-1-i])
              cb_addr[i*CB_AW +: CB_AW] <= cb_en[i+1] ?
                cb_addr[(i+1)*CB_AW +: CB_AW] - CB_AW'(1) : '0;
            else
              cb_addr[i*CB_AW +: CB_AW] <= cb_addr[(i+1)*CB_AW +: CB_AW];
          end
        end
        DIR_NEW: begin
          for (int i = 0; i < L; i++) begin
            if (i == first_lane)
              cb_addr[i*CB_AW +: CB_AW] <= en_new ? addr_new + new_off : '0;
            else if (i == partner_lane)
              cb_addr[i*CB_AW +: CB_AW] <= !cb_en[first_lane] ? '0 :
                cb_addr[first_lane*CB_AW +: CB_AW] - CB_AW'(pair_dec);
            else
              cb_addr[i*CB_AW +: CB_AW] <= '0;
          end
        end
        // Idle keeps the last addresses
        default: cb_addr <= cb_addr;
      endcase
    end
  end

  // Fixed pair mapping assumes four banks
  a_new_l4: assert property (@(posedge clk) disable iff (sys_rst)
    dir == DIR_NEW |-> L == 4);

endmodule

// ==== source/cb_bank_read.sv ====
/*
  Covariance bank memories
  Preload write port, registered per-lane reads
*/
`timescale 1ns/1ps
module cb_bank_read #(
  parameter int L     = 4,
  parameter int CB_AW = 8,
  parameter int CB_DW = 16
) (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic [L-1:0]       cb_en,
  input  logic [CB_AW*L-1:0] cb_addr,
  input  logic               wr_en,
  input  logic [1:0]         wr_bank,
  input  logic [CB_AW-1:0]   wr_addr,
  input  logic [CB_DW-1:0]   wr_data,
  output logic [L-1:0]       rd_en,
  output logic [CB_DW*L-1:0] rd_data
);

  localparam int DEPTH = 2 ** CB_AW;

  logic [CB_DW-1:0] mem [L][DEPTH];

  // One write per cycle into the selected bank
  always_ff @(posedge clk) begin
    for (int b = 0; b < L; b++) begin
      if (wr_en && wr_bank == 2'(b))
        mem[b][wr_addr] <= wr_data;
    end
  end

  // Lane i reads bank i, disabled lanes give zero
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_en   <= '0;
      rd_data <= '0;
    end else begin
      rd_en <= cb_en;
      for (int i = 0; i < L; i++) begin
        if (cb_en[i])
          rd_data[i*CB_DW +: CB_DW] <= mem[i][cb_addr[i*CB_AW +: CB_AW]];
        else
          rd_data[i*CB_DW +: CB_DW] <= '0;
      end
    end
  end

  // Preload only while the shifters are quiet
  a_wr_quiet: assert property (@(posedge clk) disable iff (sys_rst)
    wr_en |-> cb_en == '0);

endmodule

// ==== source/cb_cmd_decode.sv ====
/*
  Command decoder for the bank access path
  Four-phase req/ack, step sequencer, pipeline drain
*/
`timescale 1ns/1ps
module cb_cmd_decode import cb_pkg::*; #(
  parameter int CB_AW   = 8,
  parameter int ROW_LEN = 10,
  parameter int L       = 4
) (
  input  logic             clk,
  input  logic             sys_rst,
  input  logic             cmd_req,
  input  cb_dir_e          cmd_dir,
  input  logic [1:0]       cmd_lnum,
  input  logic [CB_AW-1:0] cmd_base,
  input  logic [7:0]       cmd_len,
  output logic             cmd_ack,
  output cb_dir_e          dir,
  output logic [1:0]       lnum,
  output logic [CB_AW-1:0] addr_new,
  output logic             en_new,
  output logic             group_bit
);

  // Drain counter must reach L
  localparam int DCW = $clog2(L + 2);

  dec_state_e       state;
  cb_dir_e          dir_q;
  logic [1:0]       lnum_q;
  logic [7:0]       len_q;
  logic [7:0]       step_cnt;
  logic [DCW-1:0]   drain_cnt;
  logic [CB_AW-1:0] addr_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state     <= ST_IDLE;
      cmd_ack   <= 1'b0;
      dir_q     <= DIR_IDLE;
      lnum_q    <= 2'b00;
      step_cnt  <= 8'd0;
      drain_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_req) begin
            dir_q     <= cmd_dir;
            lnum_q    <= cmd_lnum;
            step_cnt  <= 8'd0;
            drain_cnt <= '0;
            // Empty command goes straight to flushing
            state     <= (cmd_len == 8'd0) ? ST_DRAIN : ST_RUN;
          end
        end
        ST_RUN: begin
          step_cnt <= step_cnt + 8'd1;
          if (step_cnt == len_q - 8'd1)
            state <= ST_DRAIN;
        end
        ST_DRAIN: begin
          // L+1 flush cycles until the last data leaves the result stage
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DCW'(L)) begin
            state   <= ST_ACK;
            cmd_ack <= 1'b1;
          end
        end
        default: begin
          // Hold ack until host releases req
          if (!cmd_req) begin
            state   <= ST_IDLE;
            cmd_ack <= 1'b0;
          end
        end
      endcase
    end
  end

  // Step address and command length
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cmd_req) begin
      addr_q <= cmd_base;
      len_q  <= cmd_len;
    end else if (state == ST_RUN) begin
      addr_q <= addr_q + CB_AW'(ROW_LEN);
    end
  end

  assign en_new    = (state == ST_RUN);
  // Group toggles every four steps
  assign group_bit = (state == ST_RUN) & step_cnt[2];
  assign addr_new  = addr_q;
  assign lnum      = lnum_q;
  // Direction stays valid through drain so zeros flush out
  assign dir       = (state == ST_RUN || state == ST_DRAIN) ? dir_q : DIR_IDLE;

  // Ack comes up in the ack state only after a full flush without steps
  a_ack_state: assert property (@(posedge clk) disable iff (sys_rst)
    $rose(cmd_ack) |-> state == ST_ACK && !$past(en_new) && !$past(en_new, L + 1));

  // Zero length issues no step and flushes in its own direction
  a_zero_len: assert property (@(posedge clk) disable iff (sys_rst)
    (state == ST_IDLE && cmd_req && cmd_len == 8'd0) |=> !en_new && dir == $past(cmd_dir));

endmodule

// ==== source/cb_en_shift.sv ====
/*
  Bank enable shifter
  Left, right or landmark-pair shift of the lane enables
*/
`timescale 1ns/1ps
module cb_en_shift import cb_pkg::*; #(
  parameter int L = 4
) (
  input  logic         clk,
  input  logic         sys_rst,
  input  cb_dir_e      dir,
  input  logic [1:0]   lnum,
  input  logic         en_new,
  output logic [L-1:0] cb_en
);

  int unsigned first_lane;
  int unsigned partner_lane;

  // Pair selection of the new-landmark mode
  assign first_lane   = nl_first_lane(lnum);
  assign partner_lane = nl_partner_lane(lnum);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      cb_en <= '0;
    end else begin
      case (dir)
        // Enter at bank 0, move up
        DIR_POS: cb_en <= {cb_en[L-2:0], en_new};
        // Enter at bank L-1, move down
        DIR_NEG: cb_en <= {en_new, cb_en[L-1:1]};
        DIR_NEW: begin
          for (int i = 0; i < L; i++) begin
            if (i == first_lane)
              cb_en[i] <= en_new;
            else if (i == partner_lane)
              cb_en[i] <= cb_en[first_lane];
            else
              cb_en[i] <= 1'b0;
          end
        end
        // Idle ends any read burst
        default: cb_en <= '0;
      endcase
    end
  end

  // Pair table only defined for four banks
  a_new_l4: assert property (@(posedge clk) disable iff (sys_rst)
    dir == DIR_NEW |-> L == 4);

endmodule

// ==== source/cb_pkg.sv ====
/*
  Shared types of the covariance-bank access path
  Mapping direction enum, decoder state enum
  Lane-to-bank pairing of the new-landmark mode
*/
package cb_pkg;

  // Mapping direction, shared by decode, shifters and top
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,
    DIR_POS  = 2'b01,
    DIR_NEG  = 2'b10,
    DIR_NEW  = 2'b11
  } cb_dir_e;

  // Command decoder FSM states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_RUN   = 2'b01,
    ST_DRAIN = 2'b10,
    ST_ACK   = 2'b11
  } dec_state_e;

  /*
    New-landmark mode, four banks only
      lnum  first lane (addr)    partner lane (addr)
      11    0 (new)              1 (lane 0)
      00    2 (new)              3 (lane 2)
      01    3 (new + 3)          2 (lane 3 - 1)
      10    1 (new + 1)          0 (lane 1 - 1)
  */

  // Lane that takes the new address
  function automatic int unsigned nl_first_lane(input logic [1:0] lnum);
    case (lnum)
      2'b11:   return 0;
      2'b00:   return 2;
      2'b01:   return 3;
      default: return 1;
    endcase
  endfunction

  // Lane fed from the first lane one cycle later
  function automatic int unsigned nl_partner_lane(input logic [1:0] lnum);
    case (lnum)
      2'b11:   return 1;
      2'b00:   return 3;
      2'b01:   return 2;
      default: return 0;
    endcase
  endfunction

endpackage

// ==== sources.f ====
source/cb_pkg.sv
source/cb_cmd_decode.sv
source/cb_en_shift.sv
source/cb_addr_shift.sv
source/cb_bank_read.sv
source/cb_access_top.sv
sim/tb_cb_access.sv
